// File: rtl/bus_pkg.sv
// AXI4-Lite bus widths, response codes and the request/response types passed between blocks
package bus_pkg;

    localparam int ADDR_W = 20;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int BYTE_W = 8;                       // Only byte lane 0 carries data

    localparam int FLAT_PFX_W = 3;
    localparam int FLAT_OFS_W = ADDR_W - FLAT_PFX_W; // 17-bit RAM offset
    localparam int CPU_PFX_W  = 4;
    localparam int CPU_ADDR_W = ADDR_W - CPU_PFX_W;  // 16-bit 6502 address

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [1:0] RESP_DECERR = 2'b11;

    typedef struct packed {
        logic [FLAT_PFX_W-1:0] prefix;
        logic [FLAT_OFS_W-1:0] offset;
    } flat_view_t;

    typedef struct packed {
        logic [CPU_PFX_W-1:0]  prefix;
        logic [CPU_ADDR_W-1:0] cpu_addr;
    } cpu_view_t;

    // Same 20-bit word, seen as flat RAM offset or as CPU address
    typedef union packed {
        flat_view_t flat;
        cpu_view_t  cpu;
    } bus_addr_u;

    typedef struct packed {
        logic              valid;
        logic              write;
        bus_addr_u         addr;
        logic [BYTE_W-1:0] wdata;
        logic              be;       // Write strobe bit 0
    } axil_req_t;

    typedef struct packed {
        logic [BYTE_W-1:0] rdata;
        logic [1:0]        resp;
    } blk_resp_t;

endpackage

// File: rtl/map_pkg.sv
// PET memory map definitions: region select flags, region encodings and storage sizes
package map_pkg;

    typedef struct packed {
        logic ram_en;
        logic sid_en;
        logic magic_en;
        logic pia1_en;
        logic pia2_en;
        logic via_en;
        logic crtc_en;
        logic io_en;
        logic is_readonly;
        logic is_mirrored;
        logic reg_en;
    } region_sel_t;

    localparam region_sel_t REGION_RAM   = '{ram_en: 1'b1, default: 1'b0};
    localparam region_sel_t REGION_VRAM  = '{ram_en: 1'b1, is_mirrored: 1'b1, default: 1'b0};
    localparam region_sel_t REGION_ROM   = '{ram_en: 1'b1, is_readonly: 1'b1, default: 1'b0};
    localparam region_sel_t REGION_SID   = '{sid_en: 1'b1, default: 1'b0};
    localparam region_sel_t REGION_MAGIC = '{magic_en: 1'b1, default: 1'b0};
    localparam region_sel_t REGION_PIA1  = '{pia1_en: 1'b1, io_en: 1'b1, default: 1'b0};
    localparam region_sel_t REGION_PIA2  = '{pia2_en: 1'b1, io_en: 1'b1, default: 1'b0};
    localparam region_sel_t REGION_VIA   = '{via_en: 1'b1, io_en: 1'b1, default: 1'b0};
    localparam region_sel_t REGION_CRTC  = '{crtc_en: 1'b1, default: 1'b0}; // On-chip, no io_en
    localparam region_sel_t REGION_REG   = '{reg_en: 1'b1, default: 1'b0};

    // Address prefixes picking the access model
    localparam logic [2:0] FLAT_PREFIX = 3'b000;
    localparam logic [2:0] REG_PREFIX  = 3'b010;
    localparam logic [3:0] CPU_PREFIX  = 4'b0010;

    localparam int RAM_BYTES = 131072;
    localparam int RAM_AW    = $clog2(RAM_BYTES);

    localparam logic [15:0] MIRROR_MASK = 16'h0C00; // VRAM mirrors fold onto 8000-83FF

    localparam int REG_COUNT  = 16;
    localparam int REG_IDX_W  = $clog2(REG_COUNT);
    localparam int CRTC_COUNT = 18;
    localparam int CRTC_IDX_W = 5;

endpackage

// File: rtl/axil_front.sv
// AXI4-Lite slave front end; accepts one read or write at a time and returns its response
`timescale 1ns/1ps

module axil_front (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          s_awvalid_i,
    input  logic [bus_pkg::ADDR_W-1:0]    s_awaddr_i,
    input  logic                          s_wvalid_i,
    input  logic [bus_pkg::DATA_W-1:0]    s_wdata_i,
    input  logic [bus_pkg::STRB_W-1:0]    s_wstrb_i,
    input  logic                          s_bready_i,
    input  logic                          s_arvalid_i,
    input  logic [bus_pkg::ADDR_W-1:0]    s_araddr_i,
    input  logic                          s_rready_i,
    output logic                          s_awready_o,
    output logic                          s_wready_o,
    output logic                          s_bvalid_o,
    output logic [1:0]                    s_bresp_o,
    output logic                          s_arready_o,
    output logic                          s_rvalid_o,
    output logic [bus_pkg::DATA_W-1:0]    s_rdata_o,
    output logic [1:0]                    s_rresp_o,
    output bus_pkg::axil_req_t            req_o,
    input  logic                          done_i,
    input  bus_pkg::blk_resp_t            resp_i
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUSY,
        ST_RESP
    } state_t;

    state_t                      state_q;
    logic                        aw_rdy_q;
    logic                        ar_rdy_q;
    logic                        req_vld_q;
    logic                        write_q;
    bus_pkg::bus_addr_u          addr_q;
    logic [bus_pkg::BYTE_W-1:0]  wdata_q;
    logic                        be_q;
    bus_pkg::blk_resp_t          resp_q;

    logic wr_take;
    logic rd_take;
    logic resp_take;

    assign wr_take   = aw_rdy_q && s_awvalid_i && s_wvalid_i;
    assign rd_take   = ar_rdy_q && s_arvalid_i;
    assign resp_take = (state_q == ST_RESP) && (write_q ? s_bready_i : s_rready_i);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= ST_IDLE;
            aw_rdy_q  <= 1'b0;
            ar_rdy_q  <= 1'b0;
            req_vld_q <= 1'b0;
            write_q   <= 1'b0;
        end else begin
            req_vld_q <= 1'b0;                          // Request lasts one cycle
            case (state_q)
                ST_IDLE: begin
                    if (wr_take) begin
                        aw_rdy_q  <= 1'b0;
                        write_q   <= 1'b1;
                        req_vld_q <= 1'b1;
                        state_q   <= ST_BUSY;
                    end else if (rd_take) begin
                        ar_rdy_q  <= 1'b0;
                        write_q   <= 1'b0;
                        req_vld_q <= 1'b1;
                        state_q   <= ST_BUSY;
                    end else if (aw_rdy_q || ar_rdy_q) begin
                        aw_rdy_q <= 1'b0;                   // Offer withdrawn
                        ar_rdy_q <= 1'b0;
                    end else if (s_awvalid_i && s_wvalid_i) begin
                        aw_rdy_q <= 1'b1;                   // Writes win ties
                    end else if (s_arvalid_i && !s_awvalid_i && !s_wvalid_i) begin
                        ar_rdy_q <= 1'b1;
                    end
                end
                ST_BUSY: if (done_i) state_q <= ST_RESP;
                ST_RESP: if (resp_take) state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_take) begin
            addr_q  <= s_awaddr_i;
            wdata_q <= s_wdata_i[bus_pkg::BYTE_W-1:0];  // Lane 0 only
            be_q    <= s_wstrb_i[0];
        end else if (rd_take) begin
            addr_q  <= s_araddr_i;
            wdata_q <= '0;
            be_q    <= 1'b0;
        end
        if (state_q == ST_BUSY && done_i) resp_q <= resp_i;
    end

    assign req_o = '{valid: req_vld_q, write: write_q, addr: addr_q, wdata: wdata_q, be: be_q};

    assign s_awready_o = aw_rdy_q;
    assign s_wready_o  = aw_rdy_q;
    assign s_arready_o = ar_rdy_q;
    assign s_bvalid_o  = (state_q == ST_RESP) && write_q;
    assign s_rvalid_o  = (state_q == ST_RESP) && !write_q;
    assign s_bresp_o   = resp_q.resp;
    assign s_rresp_o   = resp_q.resp;
    assign s_rdata_o   = {{(bus_pkg::DATA_W - bus_pkg::BYTE_W){1'b0}}, resp_q.rdata};

endmodule

// File: rtl/address_decoding.sv
// Combinational PET address decoder; maps a bus address to its region select flags
`timescale 1ns/1ps

module address_decoding (
    input  bus_pkg::bus_addr_u   addr_i,
    output map_pkg::region_sel_t sel_o
);

    // CPU view decode, most specific windows ahead of their enclosing ranges
    map_pkg::region_sel_t cpu_sel;

    always_comb begin
        priority casez (addr_i.cpu.cpu_addr)
            16'b0???_????_????_????: cpu_sel = map_pkg::REGION_RAM;   // 0000-7FFF
            16'b1000_1111_????_????: cpu_sel = map_pkg::REGION_SID;   // 8F00-8FFF
            16'b1000_????_????_????: cpu_sel = map_pkg::REGION_VRAM;  // 8000-8EFF
            16'b1110_1000_0000_????: cpu_sel = map_pkg::REGION_MAGIC; // E800-E80F
            16'b1110_1000_0001_????: cpu_sel = map_pkg::REGION_PIA1;  // E810-E81F
            16'b1110_1000_001?_????: cpu_sel = map_pkg::REGION_PIA2;  // E820-E83F
            16'b1110_1000_01??_????: cpu_sel = map_pkg::REGION_VIA;   // E840-E87F
            16'b1110_1000_1???_????: cpu_sel = map_pkg::REGION_CRTC;  // E880-E8FF
            default:                 cpu_sel = map_pkg::REGION_ROM;   // 9000-E7FF, E900-FFFF
        endcase
    end

    // Prefix selects the access model
    always_comb begin
        if (addr_i.flat.prefix == map_pkg::REG_PREFIX) begin
            sel_o = map_pkg::REGION_REG;
        end else if (addr_i.flat.prefix == map_pkg::FLAT_PREFIX) begin
            sel_o = map_pkg::REGION_RAM;                      // 00000-1FFFF
        end else if (addr_i.cpu.prefix == map_pkg::CPU_PREFIX) begin
            sel_o = cpu_sel;
        end else begin
            sel_o = map_pkg::REGION_ROM;                      // Unmapped prefixes
        end
    end

endmodule

// File: rtl/memory_store.sv
// Byte-wide RAM image behind flat, CPU, VRAM and ROM views; one access per request
`timescale 1ns/1ps

module memory_store (
    input  logic                 clk_i,
    input  bus_pkg::axil_req_t   req_i,
    input  map_pkg::region_sel_t sel_i,
    output bus_pkg::blk_resp_t   resp_o
);

    logic [bus_pkg::BYTE_W-1:0] mem [map_pkg::RAM_BYTES];

    logic [bus_pkg::CPU_ADDR_W-1:0] cpu_ofs;
    logic [map_pkg::RAM_AW-1:0]     byte_ofs;
    logic                           is_flat;
    logic                           do_write;
    logic                           rom_write;

    initial begin
        for (int i = 0; i < map_pkg::RAM_BYTES; i++) begin
            mem[i] = '0;
        end
    end

    assign is_flat = (req_i.addr.flat.prefix == map_pkg::FLAT_PREFIX);
    assign cpu_ofs = sel_i.is_mirrored ? (req_i.addr.cpu.cpu_addr & ~map_pkg::MIRROR_MASK)
                                       : req_i.addr.cpu.cpu_addr;

    // CPU accesses land in bank 0
    assign byte_ofs = is_flat ? req_i.addr.flat.offset
                              : {{(map_pkg::RAM_AW - bus_pkg::CPU_ADDR_W){1'b0}}, cpu_ofs};

    assign rom_write = req_i.write && sel_i.is_readonly;
    assign do_write  = req_i.write && req_i.be && !sel_i.is_readonly;

    always_ff @(posedge clk_i) begin
        if (req_i.valid && sel_i.ram_en) begin
            if (do_write) mem[byte_ofs] <= req_i.wdata;
            resp_o.rdata <= mem[byte_ofs];            // Old contents on a write
            resp_o.resp  <= rom_write ? bus_pkg::RESP_SLVERR : bus_pkg::RESP_OKAY;
        end
    end

endmodule

// File: rtl/reg_block.sv
// On-chip register file plus CRTC index/data pair, served from the REG and CRTC regions
`timescale 1ns/1ps

module reg_block (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  bus_pkg::axil_req_t   req_i,
    input  map_pkg::region_sel_t sel_i,
    output bus_pkg::blk_resp_t   resp_o
);

    logic [bus_pkg::BYTE_W-1:0]     regs      [map_pkg::REG_COUNT];
    logic [bus_pkg::BYTE_W-1:0]     crtc_regs [map_pkg::CRTC_COUNT];
    logic [map_pkg::CRTC_IDX_W-1:0] crtc_idx_q;

    logic [map_pkg::REG_IDX_W-1:0]  reg_idx;
    logic                           is_odd;
    logic                           crtc_hit;
    logic                           wr;
    logic [bus_pkg::BYTE_W-1:0]     rd_data;

    assign reg_idx  = req_i.addr.flat.offset[map_pkg::REG_IDX_W-1:0];
    assign is_odd   = req_i.addr.cpu.cpu_addr[0];                 // Odd selects CRTC data
    assign crtc_hit = (crtc_idx_q < map_pkg::CRTC_COUNT);
    assign wr       = req_i.valid && req_i.write && req_i.be;

    always_comb begin
        rd_data = '0;
        if (sel_i.reg_en) begin
            rd_data = regs[reg_idx];
        end else if (sel_i.crtc_en) begin
            if (!is_odd) rd_data = {{(bus_pkg::BYTE_W - map_pkg::CRTC_IDX_W){1'b0}}, crtc_idx_q};
            else if (crtc_hit) rd_data = crtc_regs[crtc_idx_q];
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < map_pkg::REG_COUNT; i++) regs[i] <= '0;
            for (int i = 0; i < map_pkg::CRTC_COUNT; i++) crtc_regs[i] <= '0;
            crtc_idx_q <= '0;
        end else if (wr) begin
            if (sel_i.reg_en) begin
                regs[reg_idx] <= req_i.wdata;
            end else if (sel_i.crtc_en) begin
                if (!is_odd) crtc_idx_q <= req_i.wdata[map_pkg::CRTC_IDX_W-1:0];
                else if (crtc_hit) crtc_regs[crtc_idx_q] <= req_i.wdata; // Out of range ignored
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i.valid && (sel_i.reg_en || sel_i.crtc_en)) begin
            resp_o.rdata <= rd_data;
            resp_o.resp  <= bus_pkg::RESP_OKAY;
        end
    end

endmodule

// File: rtl/resp_merge.sv
// Selects the serving block's result for the front end, or builds DECERR for unbacked regions
`timescale 1ns/1ps

module resp_merge (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  bus_pkg::axil_req_t   req_i,
    input  map_pkg::region_sel_t sel_i,
    input  bus_pkg::blk_resp_t   mem_i,
    input  bus_pkg::blk_resp_t   regs_i,
    output logic                 done_o,
    output bus_pkg::blk_resp_t   resp_o
);

    map_pkg::region_sel_t sel_q;
    logic                 valid_q;

    // Delayed to line up with the registered block outputs
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i.valid) sel_q <= sel_i;
    end

    assign done_o = valid_q;

    always_comb begin
        if (sel_q.ram_en) begin
            resp_o = mem_i;
        end else if (sel_q.reg_en || sel_q.crtc_en) begin
            resp_o = regs_i;
        end else begin
            resp_o = '{rdata: '0, resp: bus_pkg::RESP_DECERR}; // SID, MAGIC, PIA, VIA
        end
    end

endmodule

// File: rtl/pet_bus.sv
// Top level of the PET bus slave; connects the AXI4-Lite front end to decode, storage and merge
`timescale 1ns/1ps

module pet_bus (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       s_awvalid_i,
    input  logic [bus_pkg::ADDR_W-1:0] s_awaddr_i,
    input  logic                       s_wvalid_i,
    input  logic [bus_pkg::DATA_W-1:0] s_wdata_i,
    input  logic [bus_pkg::STRB_W-1:0] s_wstrb_i,
    input  logic                       s_bready_i,
    input  logic                       s_arvalid_i,
    input  logic [bus_pkg::ADDR_W-1:0] s_araddr_i,
    input  logic                       s_rready_i,
    output logic                       s_awready_o,
    output logic                       s_wready_o,
    output logic                       s_bvalid_o,
    output logic [1:0]                 s_bresp_o,
    output logic                       s_arready_o,
    output logic                       s_rvalid_o,
    output logic [bus_pkg::DATA_W-1:0] s_rdata_o,
    output logic [1:0]                 s_rresp_o
);

    bus_pkg::axil_req_t   req;
    map_pkg::region_sel_t sel;
    bus_pkg::blk_resp_t   mem_resp;
    bus_pkg::blk_resp_t   regs_resp;
    bus_pkg::blk_resp_t   merged_resp;
    logic                 done;

    axil_front front_i (
        .clk_i, .rst_n_i,
        .s_awvalid_i, .s_awaddr_i, .s_wvalid_i, .s_wdata_i, .s_wstrb_i, .s_bready_i,
        .s_arvalid_i, .s_araddr_i, .s_rready_i,
        .s_awready_o, .s_wready_o, .s_bvalid_o, .s_bresp_o,
        .s_arready_o, .s_rvalid_o, .s_rdata_o, .s_rresp_o,
        .req_o (req),
        .done_i (done),
        .resp_i (merged_resp)
    );

    address_decoding decode_i (.addr_i (req.addr), .sel_o (sel));

    memory_store store_i (.clk_i, .req_i (req), .sel_i (sel), .resp_o (mem_resp));

    reg_block regs_i (.clk_i, .rst_n_i, .req_i (req), .sel_i (sel), .resp_o (regs_resp));

    resp_merge merge_i (
        .clk_i, .rst_n_i,
        .req_i (req), .sel_i (sel),
        .mem_i (mem_resp), .regs_i (regs_resp),
        .done_o (done), .resp_o (merged_resp)
    );

endmodule

// File: test/pet_bus_assertions.sv
// Concurrent AXI4-Lite handshake checks, bound into every axil_front instance
`timescale 1ns/1ps

module pet_bus_assertions (
    input logic                       clk_i, rst_n_i,
    input logic                       awready_i, wready_i, bvalid_i, bready_i,
    input logic                       rvalid_i, rready_i,
    input logic [1:0]                 bresp_i, rresp_i,
    input logic [bus_pkg::DATA_W-1:0] rdata_i
);

    int fail_count = 0;  // Assertion failures so far

    r_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i) && $stable(rresp_i))
        else begin
            $error("R channel changed while stalled");
            fail_count++;
        end

    b_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
        else begin
            $error("B channel changed while stalled");
            fail_count++;
        end

    // Write readies move as a pair and never while a response is pending
    aw_w_pair: assert property (@(posedge clk_i)
        (awready_i || wready_i) |-> awready_i && wready_i && !bvalid_i && !rvalid_i)
        else begin
            $error("awready and wready differ or are high with a response pending");
            fail_count++;
        end

    // One response per accepted transaction
    one_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (bvalid_i && bready_i) || (rvalid_i && rready_i) |=> !bvalid_i && !rvalid_i)
        else begin
            $error("response valid stayed high after its handshake");
            fail_count++;
        end

endmodule

bind axil_front pet_bus_assertions assert_i (
    .clk_i, .rst_n_i, .awready_i (s_awready_o), .wready_i (s_wready_o),
    .bvalid_i (s_bvalid_o), .bready_i (s_bready_i), .rvalid_i (s_rvalid_o),
    .rready_i (s_rready_i), .bresp_i (s_bresp_o), .rresp_i (s_rresp_o), .rdata_i (s_rdata_o)
);

// File: test/tb_pet_bus.sv
// Random AXI4-Lite traffic into pet_bus, checked against a memory map model; run via run_sim.sh
`timescale 1ns/1ps

module tb_pet_bus;

    localparam int CLK_NS       = 100;
    localparam int RESET_CYCLES = 10;
    localparam int N_TXN        = 600;
    localparam int TXN_CYCLES   = 40;                // Budget per transaction incl. stalls

    logic        clk, rst_n, awvalid, wvalid, bready, arvalid, rready;
    logic        awready, wready, bvalid, arready, rvalid;
    logic [19:0] awaddr, araddr;
    logic [31:0] wdata, rdata;
    logic [3:0]  wstrb;
    logic [1:0]  bresp, rresp;

    logic [7:0]  ram [map_pkg::RAM_BYTES];          // Model state
    logic [7:0]  regs [map_pkg::REG_COUNT];
    logic [7:0]  crtc [map_pkg::CRTC_COUNT];
    logic [4:0]  crtc_idx;
    int          errors = 0, checks = 0;
    int unsigned lcg_state = 37246;

    pet_bus dut_i (
        .clk_i (clk), .rst_n_i (rst_n), .s_awvalid_i (awvalid), .s_awaddr_i (awaddr),
        .s_wvalid_i (wvalid), .s_wdata_i (wdata), .s_wstrb_i (wstrb), .s_bready_i (bready),
        .s_arvalid_i (arvalid), .s_araddr_i (araddr), .s_rready_i (rready),
        .s_awready_o (awready), .s_wready_o (wready), .s_bvalid_o (bvalid), .s_bresp_o (bresp),
        .s_arready_o (arready), .s_rvalid_o (rvalid), .s_rdata_o (rdata), .s_rresp_o (rresp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(CLK_NS * (RESET_CYCLES + 2 + N_TXN * TXN_CYCLES));
        $display("Timeout: the DUT stopped answering before all transactions were done");
        $display("Done: errors found");
        $finish;
    end

    function automatic int unsigned rand_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state >> 16;                      // Upper bits have the longer period
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    // Small address pool so reads hit earlier writes and VRAM mirrors collide
    function automatic logic [19:0] pick_addr();
        logic [7:0] pages [8] = '{8'h12, 8'h80, 8'h84, 8'h8C, 8'h8F, 8'hA0, 8'hE8, 8'hF0};
        logic [7:0] page, low;
        page = pages[rand_next() % 8];
        low  = (page == 8'hE8) ? 8'(rand_next()) : 8'(rand_next() % 16);
        case (rand_next() % 4)
            0: return {3'b000, 1'((rand_next() % 4) == 0), page, low};   // Flat view mostly in bank 0
            1: return {3'b010, 9'(rand_next()), low};                    // Register file
            default: return {4'b0010, page, low};                        // CPU map
        endcase
    endfunction

    task automatic model_access(input logic wr, input logic [19:0] a, input logic [7:0] wd,
                                input logic be, output logic [7:0] rd, output logic [1:0] resp);
        logic [15:0] c;
        logic [16:0] ofs;
        logic        is_mem, ro;
        c      = a[15:0];
        rd     = 8'h00;
        resp   = bus_pkg::RESP_OKAY;
        is_mem = 1'b1;
        ro     = 1'b0;
        ofs    = {1'b0, c};
        if (a[19:17] == 3'b010) begin
            is_mem = 1'b0;
            rd = regs[a[3:0]];
            if (wr && be) regs[a[3:0]] = wd;
        end else if (a[19:17] == 3'b000) begin
            ofs = a[16:0];
        end else if (a[19:16] != 4'b0010) begin
            ro = 1'b1;                                   // Unmapped prefix acts as ROM
        end else if (c >= 16'h8000 && c < 16'h8F00) begin
            ofs = {1'b0, c & ~map_pkg::MIRROR_MASK};    // VRAM folds onto 8000-83FF
        end else if ((c >= 16'h8F00 && c < 16'h9000) || (c >= 16'hE800 && c < 16'hE880)) begin
            is_mem = 1'b0;
            resp = bus_pkg::RESP_DECERR;
        end else if (c >= 16'hE880 && c < 16'hE900) begin
            is_mem = 1'b0;
            if (!c[0]) begin
                rd = {3'b000, crtc_idx};
                if (wr && be) crtc_idx = wd[4:0];
            end else if (crtc_idx < map_pkg::CRTC_COUNT) begin
                rd = crtc[crtc_idx];
                if (wr && be) crtc[crtc_idx] = wd;
            end
        end else if (c >= 16'h8000) begin
            ro = 1'b1;                                   // ROM
        end
        if (is_mem) begin
            rd = ram[ofs];
            if (wr && ro) resp = bus_pkg::RESP_SLVERR;
            else if (wr && be) ram[ofs] = wd;
        end
    endtask

    task automatic wait_response(input logic is_wr, input logic [19:0] a,
                                 input logic [7:0] exp_rd, input logic [1:0] exp_resp);
        logic taken, stall;
        taken = 1'b0;
        while (!taken) begin
            stall  = (rand_next() % 4) == 0;
            bready = is_wr && !stall;
            rready = !is_wr && !stall;
            if (is_wr ? (bvalid && bready) : (rvalid && rready)) begin
                taken = 1'b1;
                checks++;
                if (is_wr && bresp !== exp_resp) begin
                    errors++;
                    $display("Fail at %0t: write %h bresp %b, expected %b",
                             $time, a, bresp, exp_resp);
                end
                if (!is_wr && (rresp !== exp_resp || rdata !== {24'h0, exp_rd})) begin
                    errors++;
                    $display("Fail at %0t: read %h gave %h/%b, expected %h/%b", $time, a,
                             rdata, rresp, exp_rd, exp_resp);
                end
            end
            next_cycle();
        end
        bready = 1'b0;
        rready = 1'b0;
    endtask

    task automatic write_txn(input logic [19:0] a, input logic [7:0] d, input logic be);
        logic [7:0] exp_rd;
        logic [1:0] exp_resp;
        model_access(1'b1, a, d, be, exp_rd, exp_resp);
        awaddr  = a;
        wdata   = {24'(rand_next()), d};
        wstrb   = {3'(rand_next()), be};
        awvalid = 1'b1;
        wvalid  = 1'b1;
        while (!awready) next_cycle();
        next_cycle();                                    // Handshake edge
        awvalid = 1'b0;
        wvalid  = 1'b0;
        wait_response(1'b1, a, exp_rd, exp_resp);
    endtask

    task automatic read_txn(input logic [19:0] a);
        logic [7:0] exp_rd;
        logic [1:0] exp_resp;
        model_access(1'b0, a, 8'h00, 1'b0, exp_rd, exp_resp);
        araddr  = a;
        arvalid = 1'b1;
        while (!arready) next_cycle();
        next_cycle();
        arvalid = 1'b0;
        wait_response(1'b0, a, exp_rd, exp_resp);
    endtask

    task automatic check_idle(input string when_s);
        checks++;
        if (awready || wready || arready || bvalid || rvalid || dut_i.req.valid) begin
            errors++;
            $display("Fail at %0t: ready or valid output high %s", $time, when_s);
        end
    endtask

    initial begin
        logic [19:0] a;
        rst_n    = 1'b0;
        awvalid  = 1'b0;
        wvalid   = 1'b0;
        bready   = 1'b0;
        arvalid  = 1'b0;
        rready   = 1'b0;
        awaddr   = '0;
        araddr   = '0;
        wdata    = '0;
        wstrb    = '0;
        crtc_idx = '0;
        for (int i = 0; i < map_pkg::RAM_BYTES; i++) ram[i] = 8'h00;
        for (int i = 0; i < map_pkg::REG_COUNT; i++) regs[i] = 8'h00;
        for (int i = 0; i < map_pkg::CRTC_COUNT; i++) crtc[i] = 8'h00;
        repeat (RESET_CYCLES) next_cycle();
        check_idle("during reset");
        rst_n = 1'b1;
        next_cycle();
        check_idle("after reset");
        for (int n = 0; n < N_TXN; n++) begin
            a = pick_addr();
            if (rand_next() % 2 == 0) write_txn(a, 8'(rand_next()), (rand_next() % 4) != 0);
            else read_txn(a);
        end
        errors += dut_i.front_i.assert_i.fail_count;
        $display("Checks: %0d, errors: %0d (assertion failures: %0d)", checks, errors,
                 dut_i.front_i.assert_i.fail_count);
        if (errors == 0) $display("Done: no errors");
        else $display("Done: errors found");
        $finish;
    end

endmodule

// File: pet_bus.f
rtl/bus_pkg.sv
rtl/map_pkg.sv
rtl/axil_front.sv
rtl/address_decoding.sv
rtl/memory_store.sv
rtl/reg_block.sv
rtl/resp_merge.sv
rtl/pet_bus.sv
test/pet_bus_assertions.sv
test/tb_pet_bus.sv

// File: run_sim.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module tb_pet_bus -f pet_bus.f \
    -o tb_pet_bus || { echo "Build failed"; exit 1; }
out=$(./obj_dir/tb_pet_bus)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Done: no errors" && echo "PASS" || { echo "FAIL"; exit 1; }
